// File: Bender.yml
package:
  name: xt_peripherals

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/xt_periph_pkg.sv
      - rtl/io_bus_if.sv
      - rtl/io_decoder.sv
      - rtl/ems_mapper.sv
      - rtl/io_readback.sv
      - rtl/xt_peripherals.sv

  - target: simulation
    include_dirs:
      - rtl
    files:
      - verif/tb_xt_peripherals.sv

// File: filelist.f
+incdir+rtl
rtl/xt_periph_pkg.sv
rtl/io_bus_if.sv
rtl/io_decoder.sv
rtl/ems_mapper.sv
rtl/io_readback.sv
rtl/xt_peripherals.sv
verif/tb_xt_peripherals.sv

// File: rtl/ems_mapper.sv
// EMS page mapper with four page registers at ports 260h-263h.
// Writes pass through a one-stage pipeline before reaching the registers.
// Also reports which memory window a memory cycle falls into.

`timescale 1ns/1ps
`default_nettype none

`include "xt_periph_config.svh"

module ems_mapper (
    input  logic                       clock,
    input  logic                       reset,
    io_bus_if.consumer                 bus_i,
    input  xt_periph_pkg::chip_sel_t   sel_i,
    input  logic [1:0]                 ems_address_i,
    output logic [`XT_EMS_PAGES-1:0]   window_hit_o,
    output xt_periph_pkg::bus_data_t   page_rdata_o
);
    import xt_periph_pkg::*;

    localparam int pages = `XT_EMS_PAGES;

    // Page registers
    ems_bank_t [pages-1:0] bank_q;
    logic      [pages-1:0] enable_q;

    // Decoded value of the byte on the bus
    logic      new_valid;
    ems_bank_t new_bank;
    logic      new_enable;

    // Write pipeline stage
    logic      wr_pending_q;
    ems_page_t wr_page_q;
    ems_bank_t wr_bank_q;
    logic      wr_enable_q;

    ems_page_t rd_page;
    logic      io_cycle;
    logic [3:0] win_code;

    always_comb begin
        new_valid  = 1'b0;
        new_bank   = '0;
        new_enable = 1'b0;
        if (bus_i.wdata == `XT_EMS_DISABLE_CODE) begin
            new_valid  = 1'b1;
            new_bank   = '1;
            new_enable = 1'b0;
        end else if (!bus_i.wdata[7]) begin
            new_valid  = 1'b1;
            new_bank   = bus_i.wdata[6:0];
            new_enable = 1'b1;
        end
        // 80h..FEh leave the page as it is
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wr_pending_q <= 1'b0;
        end else begin
            wr_pending_q <= sel_i.ems_io & ~bus_i.io_write_n & new_valid;
        end
    end

    always_ff @(posedge clock) begin
        wr_page_q   <= ems_page_t'(bus_i.address[1:0]);
        wr_bank_q   <= new_bank;
        wr_enable_q <= new_enable;
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            bank_q   <= '0;
            enable_q <= '0;
        end else if (wr_pending_q) begin
            bank_q[wr_page_q]   <= wr_bank_q;
            enable_q[wr_page_q] <= wr_enable_q;
        end
    end

    // Read byte for the page addressed right now
    assign rd_page = ems_page_t'(bus_i.address[1:0]);
    assign page_rdata_o = enable_q[rd_page] ? {1'b0, bank_q[rd_page]}
                                            : bus_data_t'(`XT_EMS_DISABLE_CODE);

    always_comb begin
        case (ems_address_i)
            2'd0:    win_code = `XT_EMS_WIN_A;
            2'd1:    win_code = `XT_EMS_WIN_C;
            default: win_code = `XT_EMS_WIN_D;
        endcase
    end

    assign io_cycle = ~bus_i.io_read_n | ~bus_i.io_write_n;

    // 16K windows, four in a row above the window base
    always_comb begin
        for (int k = 0; k < pages; k++) begin
            window_hit_o[k] = ~io_cycle & enable_q[k] &
                              (bus_i.address[19:14] == {win_code, ems_page_t'(k)});
        end
    end

    // An enabling write on the bus is visible in the registers two edges later
    a_write_lands: assert property (
        @(posedge clock) disable iff (reset)
        (sel_i.ems_io && !bus_i.io_write_n && !bus_i.wdata[7]) |=> ##1
            enable_q[$past(bus_i.address[1:0], 2)] &&
            (bank_q[$past(bus_i.address[1:0], 2)] == $past(bus_i.wdata[6:0], 2))
    ) else $error("EMS page register missed its pipelined write");

endmodule

`default_nettype wire

// File: rtl/io_bus_if.sv
// CPU side ISA-style bus shared by the decoder, EMS mapper and read-back.
// The top level drives it, the other blocks only observe it.

`timescale 1ns/1ps
`default_nettype none

interface io_bus_if;
    import xt_periph_pkg::*;

    bus_addr_t address;
    bus_data_t wdata;

    // Strobes, all active low
    logic      io_read_n;
    logic      io_write_n;
    logic      memory_read_n;
    logic      address_enable_n;

    modport producer (
        output address,
        output wdata,
        output io_read_n,
        output io_write_n,
        output memory_read_n,
        output address_enable_n
    );

    modport consumer (
        input  address,
        input  wdata,
        input  io_read_n,
        input  io_write_n,
        input  memory_read_n,
        input  address_enable_n
    );

endinterface

`default_nettype wire

// File: rtl/io_decoder.sv
// I/O address decoder for the XT board.
// Produces the internal select struct and the five active-low XT chip selects.

`timescale 1ns/1ps
`default_nettype none

`include "xt_periph_config.svh"

module io_decoder (
    io_bus_if.consumer                 bus_i,
    input  logic                       ems_enabled_i,
    output xt_periph_pkg::chip_sel_t   sel_o,
    output logic [4:0]                 xt_cs_n_o
);
    import xt_periph_pkg::*;

    localparam logic [15:0] ems_base = `XT_EMS_IO_BASE;
    localparam logic [15:0] lpt_port = `XT_LPT_DATA_PORT;

    logic io_cycle;
    logic decode_en;
    logic low_board;

    assign io_cycle  = ~bus_i.io_read_n | ~bus_i.io_write_n;
    assign decode_en = io_cycle & ~bus_i.address_enable_n;

    // Mainboard chips live in the first 100h ports
    assign low_board = (bus_i.address[9:8] == 2'b00);

    always_comb begin
        sel_o = '0;
        if (decode_en) begin
            if (low_board) begin
                // One 20h block per chip
                case (bus_i.address[7:5])
                    3'd0:    sel_o.dma      = 1'b1;
                    3'd1:    sel_o.pic      = 1'b1;
                    3'd2:    sel_o.pit      = 1'b1;
                    3'd3:    sel_o.ppi      = 1'b1;
                    3'd4:    sel_o.dma_page = 1'b1;
                    default: ;
                endcase
            end

            if (ems_enabled_i && (bus_i.address[15:2] == ems_base[15:2])) begin
                sel_o.ems_io = 1'b1;
            end

            if (bus_i.address[15:0] == lpt_port) begin
                sel_o.lpt_data = 1'b1;
            end
        end
    end

    // External chips take their selects active low
    assign xt_cs_n_o = ~{sel_o.dma_page, sel_o.ppi, sel_o.pit, sel_o.pic, sel_o.dma};

    // Port ranges of all blocks must stay disjoint
    a_one_select: assert final ($onehot0(sel_o))
        else $error("more than one chip select active: %b", sel_o);

endmodule

`default_nettype wire

// File: rtl/io_readback.sv
// Printer data latch and the registered read-back path to the chipset bus.
// EMS page reads win over the printer port, everything else reads 00h.

`timescale 1ns/1ps
`default_nettype none

module io_readback (
    input  logic                       clock,
    input  logic                       reset,
    io_bus_if.consumer                 bus_i,
    input  xt_periph_pkg::chip_sel_t   sel_i,
    input  xt_periph_pkg::bus_data_t   page_rdata_i,
    output xt_periph_pkg::bus_data_t   data_bus_out_o,
    output logic                       data_bus_out_valid_o
);
    import xt_periph_pkg::*;

    bus_data_t lpt_data_q;
    logic      io_read;

    assign io_read = ~bus_i.io_read_n;

    // Port 378h, comes up with all ones
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            lpt_data_q <= 8'hFF;
        end else if (sel_i.lpt_data && !bus_i.io_write_n) begin
            lpt_data_q <= bus_i.wdata;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            data_bus_out_valid_o <= 1'b0;
            data_bus_out_o       <= '0;
        end else if (io_read && sel_i.ems_io) begin
            data_bus_out_valid_o <= 1'b1;
            data_bus_out_o       <= page_rdata_i;
        end else if (io_read && sel_i.lpt_data) begin
            data_bus_out_valid_o <= 1'b1;
            data_bus_out_o       <= lpt_data_q;
        end else begin
            data_bus_out_valid_o <= 1'b0;
            data_bus_out_o       <= '0;
        end
    end

    // Memory cycles and idle cycles never drive the chipset bus
    a_flag_after_read: assert property (
        @(posedge clock) disable iff (reset)
        (bus_i.io_read_n || !bus_i.memory_read_n) |=> !data_bus_out_valid_o
    ) else $error("read-back flag raised without an I/O read");

endmodule

`default_nettype wire

// File: rtl/xt_periph_config.svh
// Address map and EMS constants for the XT peripheral glue logic.
// Include wherever a port base, window code or page count is needed.

`ifndef XT_PERIPH_CONFIG_SVH
`define XT_PERIPH_CONFIG_SVH

// EMS page registers occupy four consecutive ports from this base
`define XT_EMS_IO_BASE      16'h0260

// Printer data port
`define XT_LPT_DATA_PORT    16'h0378

// Number of EMS page registers and memory windows
`define XT_EMS_PAGES        4

// Window codes are address bits 19:16 of the window base
`define XT_EMS_WIN_A        4'hA
`define XT_EMS_WIN_C        4'hC
`define XT_EMS_WIN_D        4'hD

// Writing this byte to a page register disables the page
`define XT_EMS_DISABLE_CODE 8'hFF

`endif

// File: rtl/xt_periph_pkg.sv
// Shared types for the XT peripheral glue logic.
// Modules import this package for bus, EMS map and chip-select types.

`default_nettype none

`include "xt_periph_config.svh"

package xt_periph_pkg;

    // CPU side bus
    typedef logic [19:0] bus_addr_t;
    typedef logic [7:0]  bus_data_t;

    // EMS mapping
    typedef logic [6:0] ems_bank_t;
    typedef logic [$clog2(`XT_EMS_PAGES)-1:0] ems_page_t;

    // Decoded selects, all active high
    typedef struct packed {
        logic dma;
        logic pic;
        logic pit;
        logic ppi;
        logic dma_page;
        logic ems_io;
        logic lpt_data;
    } chip_sel_t;

endpackage

`default_nettype wire

// File: rtl/xt_peripherals.sv
// Top level of the XT peripheral glue logic.
// Takes the CPU bus as plain ports and returns XT chip selects,
// EMS window hits and the registered chipset read-back.

`timescale 1ns/1ps
`default_nettype none

`include "xt_periph_config.svh"

module xt_peripherals (
    input  logic                       clock,
    input  logic                       reset,
    // CPU bus
    input  xt_periph_pkg::bus_addr_t   address_i,
    input  xt_periph_pkg::bus_data_t   data_i,
    input  logic                       io_read_n_i,
    input  logic                       io_write_n_i,
    input  logic                       memory_read_n_i,
    input  logic                       address_enable_n_i,
    // EMS configuration
    input  logic                       ems_enabled_i,
    input  logic [1:0]                 ems_address_i,
    // External XT chips
    output logic                       dma_cs_n_o,
    output logic                       pic_cs_n_o,
    output logic                       pit_cs_n_o,
    output logic                       ppi_cs_n_o,
    output logic                       dma_page_cs_n_o,
    output logic [`XT_EMS_PAGES-1:0]   ems_window_hit_o,
    // Chipset read-back
    output xt_periph_pkg::bus_data_t   data_bus_out_o,
    output logic                       data_bus_out_valid_o
);
    import xt_periph_pkg::*;

    chip_sel_t  sel;
    logic [4:0] xt_cs_n;
    bus_data_t  page_rdata;

    io_bus_if u_bus ();

    assign u_bus.address          = address_i;
    assign u_bus.wdata            = data_i;
    assign u_bus.io_read_n        = io_read_n_i;
    assign u_bus.io_write_n       = io_write_n_i;
    assign u_bus.memory_read_n    = memory_read_n_i;
    assign u_bus.address_enable_n = address_enable_n_i;

    io_decoder u_io_decoder (
        .bus_i         (u_bus),
        .ems_enabled_i (ems_enabled_i),
        .sel_o         (sel),
        .xt_cs_n_o     (xt_cs_n)
    );

    // Already active low from the decoder
    assign dma_cs_n_o      = xt_cs_n[0];
    assign pic_cs_n_o      = xt_cs_n[1];
    assign pit_cs_n_o      = xt_cs_n[2];
    assign ppi_cs_n_o      = xt_cs_n[3];
    assign dma_page_cs_n_o = xt_cs_n[4];

    ems_mapper u_ems_mapper (
        .clock         (clock),
        .reset         (reset),
        .bus_i         (u_bus),
        .sel_i         (sel),
        .ems_address_i (ems_address_i),
        .window_hit_o  (ems_window_hit_o),
        .page_rdata_o  (page_rdata)
    );

    io_readback u_io_readback (
        .clock                (clock),
        .reset                (reset),
        .bus_i                (u_bus),
        .sel_i                (sel),
        .page_rdata_i         (page_rdata),
        .data_bus_out_o       (data_bus_out_o),
        .data_bus_out_valid_o (data_bus_out_valid_o)
    );

endmodule

`default_nettype wire

// File: verif/tb_xt_peripherals.sv
// Table-driven testbench for the XT peripheral glue logic.
// Applies bus cycles from a stimulus table and checks chip selects,
// EMS window hits and the registered read-back against a reference model.

`timescale 1ns/1ps
`default_nettype none

`include "xt_periph_config.svh"

module tb_xt_peripherals;

    localparam int reset_cycles = 8;
    localparam logic [15:0] ems_base = `XT_EMS_IO_BASE;
    localparam logic [15:0] lpt_port = `XT_LPT_DATA_PORT;

    // Table operations
    localparam int op_wr       = 0;
    localparam int op_wr_rnd   = 1;
    localparam int op_rd       = 2;
    localparam int op_rd_rnd   = 3;
    localparam int op_cs       = 4;
    localparam int op_cs_noaen = 5;
    localparam int op_mem      = 6;
    localparam int op_mem_io   = 7;

    logic        clock;
    logic        reset;
    logic [19:0] address;
    logic [7:0]  data;
    logic        io_read_n;
    logic        io_write_n;
    logic        memory_read_n;
    logic        address_enable_n;
    logic        ems_enabled;
    logic [1:0]  ems_address;

    logic        dma_cs_n;
    logic        pic_cs_n;
    logic        pit_cs_n;
    logic        ppi_cs_n;
    logic        dma_page_cs_n;
    logic [3:0]  window_hit;
    logic [7:0]  data_bus_out;
    logic        data_bus_out_valid;

    logic [4:0]  cs_n;
    logic [15:0] readback;

    // Stimulus table, one column per queue
    string       t_name[$];
    int          t_op[$];
    logic [19:0] t_addr[$];
    logic [7:0]  t_data[$];
    logic        t_ems_en[$];
    logic [1:0]  t_win[$];
    logic [15:0] t_exp[$];

    // Reference model of the EMS registers and the printer latch
    logic [6:0]  ref_bank[4];
    logic        ref_en[4];
    logic [7:0]  ref_lpt;

    int error_count;
    int check_count;
    int cycle_count;
    int cycle_limit;

    xt_peripherals u_xt_peripherals (
        .clock                (clock),
        .reset                (reset),
        .address_i            (address),
        .data_i               (data),
        .io_read_n_i          (io_read_n),
        .io_write_n_i         (io_write_n),
        .memory_read_n_i      (memory_read_n),
        .address_enable_n_i   (address_enable_n),
        .ems_enabled_i        (ems_enabled),
        .ems_address_i        (ems_address),
        .dma_cs_n_o           (dma_cs_n),
        .pic_cs_n_o           (pic_cs_n),
        .pit_cs_n_o           (pit_cs_n),
        .ppi_cs_n_o           (ppi_cs_n),
        .dma_page_cs_n_o      (dma_page_cs_n),
        .ems_window_hit_o     (window_hit),
        .data_bus_out_o       (data_bus_out),
        .data_bus_out_valid_o (data_bus_out_valid)
    );

    assign cs_n     = {dma_page_cs_n, ppi_cs_n, pit_cs_n, pic_cs_n, dma_cs_n};
    assign readback = {7'b0, data_bus_out_valid, data_bus_out};

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("%0d errors in %0d checks", error_count, check_count);
            $display("Test failed");
            $finish;
        end
    end

    task automatic add_entry(input string name, input int op, input logic [19:0] addr,
                             input logic [7:0] d, input logic ems_en, input logic [1:0] win,
                             input logic [15:0] exp);
        t_name.push_back(name);
        t_op.push_back(op);
        t_addr.push_back(addr);
        t_data.push_back(d);
        t_ems_en.push_back(ems_en);
        t_win.push_back(win);
        t_exp.push_back(exp);
    endtask

    task automatic check(input string name, input logic [15:0] exp, input logic [15:0] act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    // Write rule: FFh disables, below 80h enables, anything else is ignored
    task automatic model_write(input logic [19:0] addr, input logic [7:0] d, input logic ems_en);
        int page;
        page = addr[1:0];
        if (ems_en && addr[15:2] == ems_base[15:2]) begin
            if (d == `XT_EMS_DISABLE_CODE) begin
                ref_en[page]   = 1'b0;
                ref_bank[page] = 7'h7F;
            end else if (d < 8'h80) begin
                ref_en[page]   = 1'b1;
                ref_bank[page] = d[6:0];
            end
        end
        if (addr[15:0] == lpt_port) begin
            ref_lpt = d;
        end
    endtask

    // Expected {flag, byte} for an I/O read
    function automatic logic [15:0] predict_read(input logic [19:0] addr, input logic ems_en);
        int page;
        page = addr[1:0];
        if (ems_en && addr[15:2] == ems_base[15:2]) begin
            if (ref_en[page]) begin
                return {8'h01, 1'b0, ref_bank[page]};
            end
            return 16'h01FF;
        end
        if (addr[15:0] == lpt_port) begin
            return {8'h01, ref_lpt};
        end
        return 16'h0000;
    endfunction

    task automatic build_table();
        logic [31:0] rnd;
        add_entry("cs_dma",      op_cs,       20'h00000, 8'h00, 1'b1, 2'd0, 16'h001E);
        add_entry("cs_pic",      op_cs,       20'h00020, 8'h00, 1'b1, 2'd0, 16'h001D);
        add_entry("cs_pit",      op_cs,       20'h00040, 8'h00, 1'b1, 2'd0, 16'h001B);
        add_entry("cs_ppi",      op_cs,       20'h00060, 8'h00, 1'b1, 2'd0, 16'h0017);
        add_entry("cs_dma_page", op_cs,       20'h00080, 8'h00, 1'b1, 2'd0, 16'h000F);
        add_entry("cs_bit8",     op_cs,       20'h00100, 8'h00, 1'b1, 2'd0, 16'h001F);
        add_entry("cs_no_aen",   op_cs_noaen, 20'h00000, 8'h00, 1'b1, 2'd0, 16'h001F);
        add_entry("lpt_reset",   op_rd,       20'h00378, 8'h00, 1'b1, 2'd0, 16'h01FF);
        add_entry("lpt_write",   op_wr,       20'h00378, 8'h5A, 1'b1, 2'd0, 16'h0000);
        add_entry("lpt_read",    op_rd,       20'h00378, 8'h00, 1'b1, 2'd0, 16'h015A);
        add_entry("ems_reset",   op_rd,       20'h00260, 8'h00, 1'b1, 2'd0, 16'h01FF);
        add_entry("ems_wr0",     op_wr,       20'h00260, 8'h12, 1'b1, 2'd0, 16'h0000);
        add_entry("ems_wr1",     op_wr,       20'h00261, 8'h34, 1'b1, 2'd0, 16'h0000);
        add_entry("ems_wr2",     op_wr,       20'h00262, 8'h56, 1'b1, 2'd0, 16'h0000);
        add_entry("ems_wr3",     op_wr,       20'h00263, 8'h7F, 1'b1, 2'd0, 16'h0000);
        add_entry("ems_rd0",     op_rd,       20'h00260, 8'h00, 1'b1, 2'd0, 16'h0112);
        add_entry("ems_rd1",     op_rd,       20'h00261, 8'h00, 1'b1, 2'd0, 16'h0134);
        add_entry("ems_rd2",     op_rd,       20'h00262, 8'h00, 1'b1, 2'd0, 16'h0156);
        add_entry("ems_rd3",     op_rd,       20'h00263, 8'h00, 1'b1, 2'd0, 16'h017F);
        add_entry("ems_disable", op_wr,       20'h00261, 8'hFF, 1'b1, 2'd0, 16'h0000);
        add_entry("ems_rd_off",  op_rd,       20'h00261, 8'h00, 1'b1, 2'd0, 16'h01FF);
        add_entry("ems_wr_90",   op_wr,       20'h00262, 8'h90, 1'b1, 2'd0, 16'h0000);
        add_entry("ems_rd_keep", op_rd,       20'h00262, 8'h00, 1'b1, 2'd0, 16'h0156);
        add_entry("ems_off_wr",  op_wr,       20'h00260, 8'h01, 1'b0, 2'd0, 16'h0000);
        add_entry("ems_off_rd",  op_rd,       20'h00260, 8'h00, 1'b0, 2'd0, 16'h0000);
        add_entry("ems_on_rd",   op_rd,       20'h00260, 8'h00, 1'b1, 2'd0, 16'h0112);
        // Pages 0, 2 and 3 are enabled from here on
        add_entry("hit_a_p0",    op_mem,      20'hA0000, 8'h00, 1'b1, 2'd0, 16'h0001);
        add_entry("hit_a_p1",    op_mem,      20'hA4000, 8'h00, 1'b1, 2'd0, 16'h0000);
        add_entry("hit_a_p2",    op_mem,      20'hA8000, 8'h00, 1'b1, 2'd0, 16'h0004);
        add_entry("hit_a_p3",    op_mem,      20'hAC000, 8'h00, 1'b1, 2'd0, 16'h0008);
        add_entry("hit_c_p0",    op_mem,      20'hC0000, 8'h00, 1'b1, 2'd1, 16'h0001);
        add_entry("hit_c_p3",    op_mem,      20'hCC000, 8'h00, 1'b1, 2'd1, 16'h0008);
        add_entry("hit_d_p0",    op_mem,      20'hD0000, 8'h00, 1'b1, 2'd2, 16'h0001);
        add_entry("hit_d_p2",    op_mem,      20'hD8000, 8'h00, 1'b1, 2'd2, 16'h0004);
        add_entry("hit_d3_p1",   op_mem,      20'hD4000, 8'h00, 1'b1, 2'd3, 16'h0000);
        add_entry("hit_d3_p3",   op_mem,      20'hDC000, 8'h00, 1'b1, 2'd3, 16'h0008);
        add_entry("hit_wrong",   op_mem,      20'hA0000, 8'h00, 1'b1, 2'd1, 16'h0000);
        add_entry("hit_io",      op_mem_io,   20'hA0000, 8'h00, 1'b1, 2'd0, 16'h0000);
        for (int k = 0; k < `XT_EMS_PAGES; k++) begin
            rnd = $urandom;
            add_entry($sformatf("rnd_wr%0d", k), op_wr_rnd, 20'h00260 + 20'(k),
                      {1'b0, rnd[6:0]}, 1'b1, 2'd0, 16'h0000);
            add_entry($sformatf("rnd_rd%0d", k), op_rd_rnd, 20'h00260 + 20'(k),
                      8'h00, 1'b1, 2'd0, 16'h0000);
        end
    endtask

    // One entry takes two cycles, the second one idle
    task automatic apply_entry(input int i);
        int op;
        op = t_op[i];
        address          = t_addr[i];
        data             = t_data[i];
        ems_enabled      = t_ems_en[i];
        ems_address      = t_win[i];
        io_read_n        = !(op inside {op_rd, op_rd_rnd, op_cs, op_cs_noaen, op_mem_io});
        io_write_n       = !(op inside {op_wr, op_wr_rnd});
        memory_read_n    = !(op inside {op_mem, op_mem_io});
        address_enable_n = (op == op_cs_noaen);
        @(posedge clock);
        @(negedge clock);
        case (op)
            op_rd:              check(t_name[i], t_exp[i], readback);
            op_rd_rnd:          check(t_name[i], predict_read(t_addr[i], t_ems_en[i]), readback);
            op_cs, op_cs_noaen: check(t_name[i], t_exp[i], {11'b0, cs_n});
            op_mem, op_mem_io:  check(t_name[i], t_exp[i], {12'b0, window_hit});
            default:            check(t_name[i], 16'h0000, readback);
        endcase
        if (op == op_wr || op == op_wr_rnd) begin
            model_write(t_addr[i], t_data[i], t_ems_en[i]);
        end
        io_read_n        = 1'b1;
        io_write_n       = 1'b1;
        memory_read_n    = 1'b1;
        address_enable_n = 1'b1;
        @(posedge clock);
        @(negedge clock);
        check({t_name[i], "_idle"}, 16'h0000, readback);
    endtask

    initial begin
        void'($urandom(32'h90f8));
        error_count      = 0;
        check_count      = 0;
        cycle_count      = 0;
        reset            = 1'b1;
        address          = '0;
        data             = '0;
        io_read_n        = 1'b1;
        io_write_n       = 1'b1;
        memory_read_n    = 1'b1;
        address_enable_n = 1'b1;
        ems_enabled      = 1'b0;
        ems_address      = 2'd0;
        for (int k = 0; k < 4; k++) begin
            ref_en[k]   = 1'b0;
            ref_bank[k] = 7'h00;
        end
        ref_lpt = 8'hFF;
        build_table();
        cycle_limit = 4 * t_name.size() + reset_cycles;

        repeat (reset_cycles) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        @(posedge clock);
        @(negedge clock);
        check("after_reset", 16'h0000, readback);

        for (int i = 0; i < t_name.size(); i++) begin
            apply_entry(i);
        end

        $display("%0d errors in %0d checks", error_count, check_count);
        if (error_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
